//--- run_sim.sh
#!/bin/bash
# build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f tb.f --top-module cpu_tb -o cpu_tb_sim > build.log 2>&1 \
	&& ./obj_dir/cpu_tb_sim > sim.log 2>&1 \
	|| { echo "build or run error, see build.log and sim.log"; exit 1; }
grep -q "Simulation completed successfully" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }

//--- source/cpu_ifs.sv
`timescale 1ns/1ps

// decoded instruction and operands, one entry per cycle
interface decode_ex_if #(
	parameter int DATA_W = cpu_pkg::DATA_W
);
	cpu_pkg::ex_ctrl_t ctrl;
	logic [DATA_W-1:0] ra_data;
	logic [DATA_W-1:0] rb_data;
	logic [cpu_pkg::REG_IDX_W-1:0] rd;
	logic [cpu_pkg::IMM_W-1:0] imm;

	modport source (output ctrl, ra_data, rb_data, rd, imm);
	modport sink (input ctrl, ra_data, rb_data, rd, imm);
endinterface

// register file write request
interface writeback_if #(
	parameter int DATA_W = cpu_pkg::DATA_W
);
	logic wr_en;
	logic [cpu_pkg::REG_IDX_W-1:0] rd;
	cpu_pkg::part_sel_t part;
	logic [DATA_W-1:0] wr_data;

	modport source (output wr_en, rd, part, wr_data);
	modport sink (input wr_en, rd, part, wr_data);
endinterface

//--- source/cpu_pkg.sv
package cpu_pkg;

	localparam int DATA_W = 64;
	localparam int INSTR_W = 32;
	localparam int REG_IDX_W = 5;
	localparam int IMM_W = 16;

	// top six bits of the instruction word
	typedef enum logic [5:0] {
		OP_LW    = 6'b100000,
		OP_SW    = 6'b100001,
		OP_BEQ   = 6'b100010,
		OP_BNE   = 6'b100011,
		OP_RTYPE = 6'b101010,
		OP_NOP   = 6'b111100
	} opcode_t;

	// low six bits of an R-type instruction
	typedef enum logic [5:0] {
		FN_AND = 6'd0,
		FN_OR  = 6'd1,
		FN_XOR = 6'd2,
		FN_NOT = 6'd3,
		FN_MOV = 6'd4,
		FN_ADD = 6'd5,
		FN_SUB = 6'd6
	} func_t;

	typedef enum logic [1:0] {
		LANE_B = 2'b00,
		LANE_H = 2'b01,
		LANE_W = 2'b10,
		LANE_D = 2'b11
	} lane_w_t;

	// even bytes are the upper byte of each halfword
	typedef enum logic [2:0] {
		PART_ALL   = 3'b000,
		PART_UPPER = 3'b001,
		PART_LOWER = 3'b010,
		PART_EVEN  = 3'b011,
		PART_ODD   = 3'b100
	} part_sel_t;

	typedef struct packed {
		logic is_rtype;
		logic is_load;
		logic is_store;
		func_t func;
		lane_w_t lane_w;
		part_sel_t part;
	} ex_ctrl_t;

endpackage

//--- source/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
	parameter int DATA_W = cpu_pkg::DATA_W
) (
	input logic clk,
	input logic reset,
	input logic [cpu_pkg::INSTR_W-1:0] instruction,
	input logic [DATA_W-1:0] data_in,
	output logic [cpu_pkg::INSTR_W-1:0] pc,
	output logic [DATA_W-1:0] data_out,
	output logic [cpu_pkg::INSTR_W-1:0] mem_addr,
	output logic mem_en,
	output logic mem_wr_en
);
	logic [cpu_pkg::INSTR_W-1:0] instr_q;
	logic branch_taken;
	logic [cpu_pkg::IMM_W-1:0] branch_target;
	logic [cpu_pkg::REG_IDX_W-1:0] ra_idx;
	logic [cpu_pkg::REG_IDX_W-1:0] rb_idx;
	logic [cpu_pkg::REG_IDX_W-1:0] rd_idx;
	logic [DATA_W-1:0] ra_val;
	logic [DATA_W-1:0] rb_val;
	logic [DATA_W-1:0] rd_val;
	logic [cpu_pkg::REG_IDX_W-1:0] mem_rd;
	cpu_pkg::part_sel_t mem_part;
	logic [DATA_W-1:0] mem_result;
	logic mem_is_load;
	logic mem_is_rtype;

	decode_ex_if #(.DATA_W(DATA_W)) dx_if ();
	writeback_if #(.DATA_W(DATA_W)) wb_if ();

	fetch_unit u_fetch (
		.clk(clk),
		.reset(reset),
		.instruction(instruction),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.pc(pc),
		.instr_q(instr_q)
	);

	decode_unit #(.DATA_W(DATA_W)) u_decode (
		.clk(clk),
		.reset(reset),
		.instr_q(instr_q),
		.ra_idx(ra_idx),
		.rb_idx(rb_idx),
		.rd_idx(rd_idx),
		.ra_val(ra_val),
		.rb_val(rb_val),
		.rd_val(rd_val),
		.branch_taken(branch_taken),
		.branch_target(branch_target),
		.ex(dx_if)
	);

	reg_file #(.DATA_W(DATA_W)) u_regs (
		.clk(clk),
		.reset(reset),
		.ra_idx(ra_idx),
		.rb_idx(rb_idx),
		.rd_idx(rd_idx),
		.ra_val(ra_val),
		.rb_val(rb_val),
		.rd_val(rd_val),
		.wb(wb_if)
	);

	execute_stage #(.DATA_W(DATA_W)) u_execute (
		.clk(clk),
		.reset(reset),
		.ex(dx_if),
		.data_out(data_out),
		.mem_addr(mem_addr),
		.mem_en(mem_en),
		.mem_wr_en(mem_wr_en),
		.mem_rd(mem_rd),
		.mem_part(mem_part),
		.mem_result(mem_result),
		.mem_is_load(mem_is_load),
		.mem_is_rtype(mem_is_rtype)
	);

	writeback_stage #(.DATA_W(DATA_W)) u_writeback (
		.clk(clk),
		.reset(reset),
		.mem_rd(mem_rd),
		.mem_part(mem_part),
		.mem_result(mem_result),
		.mem_is_load(mem_is_load),
		.mem_is_rtype(mem_is_rtype),
		.data_in(data_in),
		.wb(wb_if)
	);

endmodule

//--- source/decode_unit.sv
`timescale 1ns/1ps

module decode_unit #(
	parameter int DATA_W = cpu_pkg::DATA_W
) (
	input logic clk,
	input logic reset,
	input logic [cpu_pkg::INSTR_W-1:0] instr_q,
	output logic [cpu_pkg::REG_IDX_W-1:0] ra_idx,
	output logic [cpu_pkg::REG_IDX_W-1:0] rb_idx,
	output logic [cpu_pkg::REG_IDX_W-1:0] rd_idx,
	input logic [DATA_W-1:0] ra_val,
	input logic [DATA_W-1:0] rb_val,
	input logic [DATA_W-1:0] rd_val,
	output logic branch_taken,
	output logic [cpu_pkg::IMM_W-1:0] branch_target,
	decode_ex_if.source ex
);
	cpu_pkg::opcode_t opcode;
	cpu_pkg::ex_ctrl_t ctrl;
	logic [cpu_pkg::REG_IDX_W-1:0] f_rd;
	logic [cpu_pkg::REG_IDX_W-1:0] f_ra;
	logic [cpu_pkg::REG_IDX_W-1:0] f_rb;
	logic [cpu_pkg::IMM_W-1:0] imm;
	logic is_rtype;
	logic is_load;
	logic is_store;
	logic is_beq;
	logic is_bne;

	// opcode | rd | ra | rb | part | lane | func
	assign opcode = cpu_pkg::opcode_t'(instr_q[31:26]);
	assign f_rd = instr_q[25:21];
	assign f_ra = instr_q[20:16];
	assign f_rb = instr_q[15:11];
	assign imm = instr_q[15:0];

	assign is_rtype = (opcode == cpu_pkg::OP_RTYPE);
	assign is_load = (opcode == cpu_pkg::OP_LW);
	assign is_store = (opcode == cpu_pkg::OP_SW);
	assign is_beq = (opcode == cpu_pkg::OP_BEQ);
	assign is_bne = (opcode == cpu_pkg::OP_BNE);

	// store data comes through port a from the rd field
	assign ra_idx = is_store ? f_rd : (is_rtype ? f_ra : '0);
	assign rb_idx = is_rtype ? f_rb : '0;
	assign rd_idx = f_rd;

	// branch resolves here, no forwarding into this compare
	assign branch_taken = (is_beq && rd_val == '0) || (is_bne && rd_val != '0);
	assign branch_target = imm;

	always_comb
	begin
		ctrl = '0;
		ctrl.is_rtype = is_rtype;
		ctrl.is_load = is_load;
		ctrl.is_store = is_store;
		if (is_rtype)
		begin
			ctrl.func = cpu_pkg::func_t'(instr_q[5:0]);
			ctrl.lane_w = cpu_pkg::lane_w_t'(instr_q[7:6]);
			ctrl.part = cpu_pkg::part_sel_t'(instr_q[10:8]);
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			ex.ctrl <= '0;
		else
			ex.ctrl <= ctrl;
	end

	// operands and fields, qualified by ctrl downstream
	always_ff @(posedge clk)
	begin
		ex.ra_data <= ra_val;
		ex.rb_data <= rb_val;
		ex.rd <= f_rd;
		ex.imm <= imm;
	end

endmodule

//--- source/execute_stage.sv
`timescale 1ns/1ps

module execute_stage #(
	parameter int DATA_W = cpu_pkg::DATA_W
) (
	input logic clk,
	input logic reset,
	decode_ex_if.sink ex,
	output logic [DATA_W-1:0] data_out,
	output logic [cpu_pkg::INSTR_W-1:0] mem_addr,
	output logic mem_en,
	output logic mem_wr_en,
	output logic [cpu_pkg::REG_IDX_W-1:0] mem_rd,
	output cpu_pkg::part_sel_t mem_part,
	output logic [DATA_W-1:0] mem_result,
	output logic mem_is_load,
	output logic mem_is_rtype
);
	localparam int PAD_W = cpu_pkg::INSTR_W - cpu_pkg::IMM_W;

	logic [DATA_W-1:0] alu_result;

	simd_alu #(
		.DATA_W(DATA_W)
	) u_alu (
		.func(ex.ctrl.func),
		.lane_w(ex.ctrl.lane_w),
		.a(ex.ra_data),
		.b(ex.rb_data),
		.result(alu_result)
	);

	// one-cycle pulses, one per load or store
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			mem_en <= 1'b0;
			mem_wr_en <= 1'b0;
			mem_is_load <= 1'b0;
			mem_is_rtype <= 1'b0;
		end
		else
		begin
			mem_en <= ex.ctrl.is_load || ex.ctrl.is_store;
			mem_wr_en <= ex.ctrl.is_store;
			mem_is_load <= ex.ctrl.is_load;
			mem_is_rtype <= ex.ctrl.is_rtype;
		end
	end

	// absolute address from the zero-extended immediate
	always_ff @(posedge clk)
	begin
		mem_addr <= {{PAD_W{1'b0}}, ex.imm};
		data_out <= ex.ra_data;
		mem_result <= alu_result;
		mem_rd <= ex.rd;
		mem_part <= ex.ctrl.part;
	end

	a_wr_needs_en: assert property (@(posedge clk) disable iff (reset)
		mem_wr_en |-> mem_en);

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
	input logic clk,
	input logic reset,
	input logic [cpu_pkg::INSTR_W-1:0] instruction,
	input logic branch_taken,
	input logic [cpu_pkg::IMM_W-1:0] branch_target,
	output logic [cpu_pkg::INSTR_W-1:0] pc,
	output logic [cpu_pkg::INSTR_W-1:0] instr_q
);
	localparam int PAD_W = cpu_pkg::INSTR_W - cpu_pkg::IMM_W;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pc <= '0;
			instr_q <= '0;
		end
		else if (branch_taken)
		begin
			// redirect and drop the word fetched behind the branch
			pc <= {{PAD_W{1'b0}}, branch_target};
			instr_q <= '0;
		end
		else
		begin
			pc <= pc + 32'd4;
			instr_q <= instruction;
		end
	end

	a_branch_redirect: assert property (@(posedge clk) disable iff (reset)
		branch_taken |=> pc == {{PAD_W{1'b0}}, $past(branch_target)});

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
	parameter int DATA_W = cpu_pkg::DATA_W
) (
	input logic clk,
	input logic reset,
	input logic [cpu_pkg::REG_IDX_W-1:0] ra_idx,
	input logic [cpu_pkg::REG_IDX_W-1:0] rb_idx,
	input logic [cpu_pkg::REG_IDX_W-1:0] rd_idx,
	output logic [DATA_W-1:0] ra_val,
	output logic [DATA_W-1:0] rb_val,
	output logic [DATA_W-1:0] rd_val,
	writeback_if.sink wb
);
	localparam int HALF = DATA_W / 2;

	logic [DATA_W-1:0] regs [32];
	logic [DATA_W-1:0] wr_mask;

	assign ra_val = regs[ra_idx];
	assign rb_val = regs[rb_idx];
	assign rd_val = regs[rd_idx];

	// bits touched by each part select
	always_comb
	begin
		case (wb.part)
			cpu_pkg::PART_ALL: wr_mask = '1;
			cpu_pkg::PART_UPPER: wr_mask = {{HALF{1'b1}}, {HALF{1'b0}}};
			cpu_pkg::PART_LOWER: wr_mask = {{HALF{1'b0}}, {HALF{1'b1}}};
			cpu_pkg::PART_EVEN: wr_mask = {(DATA_W / 16){16'hff00}};
			cpu_pkg::PART_ODD: wr_mask = {(DATA_W / 16){16'h00ff}};
			default: wr_mask = '0;
		endcase
	end

	// falling edge write so decode sees it in the same cycle
	always_ff @(negedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wb.wr_en && wb.rd != '0)
			regs[wb.rd] <= (regs[wb.rd] & ~wr_mask) | (wb.wr_data & wr_mask);
	end

	a_part_known: assert property (@(negedge clk) disable iff (reset)
		wb.wr_en |-> !$isunknown(wb.part));

endmodule

//--- source/simd_alu.sv
`timescale 1ns/1ps

module simd_alu #(
	parameter int DATA_W = cpu_pkg::DATA_W
) (
	input cpu_pkg::func_t func,
	input cpu_pkg::lane_w_t lane_w,
	input logic [DATA_W-1:0] a,
	input logic [DATA_W-1:0] b,
	output logic [DATA_W-1:0] result
);
	localparam int NB = DATA_W / 8;

	logic do_sub;
	logic [DATA_W-1:0] b_eff;
	logic [DATA_W-1:0] sum;
	logic [2:0] lane_mask;

	assign do_sub = (func == cpu_pkg::FN_SUB);
	assign b_eff = do_sub ? ~b : b;
	// byte offset bits that stay inside one lane
	assign lane_mask = 3'((4'd1 << lane_w) - 4'd1);

	// byte-sliced adder with the carry chain cut at lane boundaries
	always_comb
	begin
		logic c;
		c = 1'b0;
		for (int i = 0; i < NB; i++)
		begin
			// each new lane starts with the +1 of two's complement for sub
			if ((3'(i) & lane_mask) == 3'd0)
				c = do_sub;
			{c, sum[8 * i +: 8]} = {1'b0, a[8 * i +: 8]} + {1'b0, b_eff[8 * i +: 8]} + {8'd0, c};
		end
	end

	always_comb
	begin
		case (func)
			cpu_pkg::FN_AND: result = a & b;
			cpu_pkg::FN_OR: result = a | b;
			cpu_pkg::FN_XOR: result = a ^ b;
			cpu_pkg::FN_NOT: result = ~a;
			cpu_pkg::FN_MOV: result = a;
			cpu_pkg::FN_ADD,
			cpu_pkg::FN_SUB: result = sum;
			default: result = '0;
		endcase
	end

endmodule

//--- source/writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage #(
	parameter int DATA_W = cpu_pkg::DATA_W
) (
	input logic clk,
	input logic reset,
	input logic [cpu_pkg::REG_IDX_W-1:0] mem_rd,
	input cpu_pkg::part_sel_t mem_part,
	input logic [DATA_W-1:0] mem_result,
	input logic mem_is_load,
	input logic mem_is_rtype,
	input logic [DATA_W-1:0] data_in,
	writeback_if.source wb
);
	logic is_load_q;
	logic [DATA_W-1:0] result_q;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			wb.wr_en <= 1'b0;
			is_load_q <= 1'b0;
		end
		else
		begin
			wb.wr_en <= mem_is_load || mem_is_rtype;
			is_load_q <= mem_is_load;
		end
	end

	always_ff @(posedge clk)
	begin
		wb.rd <= mem_rd;
		result_q <= mem_result;
		// loads always fill the whole register
		if (mem_is_load)
			wb.part <= cpu_pkg::PART_ALL;
		else
			wb.part <= mem_part;
	end

	// read data arrives this cycle from the synchronous memory
	assign wb.wr_data = is_load_q ? data_in : result_q;

endmodule

//--- tb.f
+incdir+testbench
source/cpu_pkg.sv
source/cpu_ifs.sv
source/fetch_unit.sv
source/decode_unit.sv
source/reg_file.sv
source/simd_alu.sv
source/execute_stage.sv
source/writeback_stage.sv
source/cpu_top.sv
testbench/cpu_tb.sv

//--- testbench/cpu_ref.svh
`ifndef CPU_REF_SVH
`define CPU_REF_SVH

// one expected store to data memory
typedef struct packed {
	logic [31:0] addr;
	logic [63:0] data;
} store_t;

typedef store_t store_list_t[$];

function automatic logic [31:0] rtype_word(cpu_pkg::func_t fn, int rd, int ra, int rb,
		int part, int lane);
	return {cpu_pkg::OP_RTYPE, 5'(rd), 5'(ra), 5'(rb), 3'(part), 2'(lane), fn};
endfunction

// lw, sw and branches use rd plus a 16 bit immediate
function automatic logic [31:0] itype_word(cpu_pkg::opcode_t op, int rd, int imm);
	return {op, 5'(rd), 5'd0, 16'(imm)};
endfunction

function automatic logic [31:0] nop_word();
	return {cpu_pkg::OP_NOP, 26'd0};
endfunction

task automatic start_program(string name);
	cur_test = name;
	prog_len = 0;
	for (int i = 0; i < PROG_SLOTS; i++)
		prog[i] = nop_word();
endtask

task automatic push_word(logic [31:0] w);
	prog[prog_len] = w;
	prog_len++;
endtask

// two nops behind every instruction keep producers and consumers apart
task automatic emit_spaced(logic [31:0] w);
	push_word(w);
	push_word(nop_word());
	push_word(nop_word());
endtask

// branch over a store, the target holds another store
task automatic branch_over(cpu_pkg::opcode_t op, int rd, int skip_addr, int hit_addr);
	int target;
	target = (prog_len + 4) * 4;
	push_word(itype_word(op, rd, target));
	push_word(nop_word());
	push_word(itype_word(cpu_pkg::OP_SW, rd, skip_addr));
	push_word(nop_word());
	emit_spaced(itype_word(cpu_pkg::OP_SW, rd, hit_addr));
endtask

function automatic logic [63:0] part_mask(int part);
	case (part)
		0: return '1;
		1: return {{32{1'b1}}, {32{1'b0}}};
		2: return {{32{1'b0}}, {32{1'b1}}};
		3: return {4{16'hff00}};
		4: return {4{16'h00ff}};
		default: return '0;
	endcase
endfunction

// independent lanes, each result wraps inside its own lane
function automatic logic [63:0] lane_op(logic [63:0] a, logic [63:0] b, int lane, bit sub);
	int bits;
	logic [63:0] mask;
	logic [63:0] av;
	logic [63:0] bv;
	logic [63:0] res;
	bits = 8 << lane;
	mask = (bits == 64) ? '1 : (64'd1 << bits) - 64'd1;
	res = '0;
	for (int l = 0; l < 64 / bits; l++)
	begin
		av = (a >> (l * bits)) & mask;
		bv = (b >> (l * bits)) & mask;
		res |= ((sub ? av - bv : av + bv) & mask) << (l * bits);
	end
	return res;
endfunction

// sequential interpreter, returns the stores in program order
function automatic store_list_t run_reference();
	logic [63:0] regs [32];
	logic [63:0] mem [256];
	logic [31:0] w;
	logic [63:0] a;
	logic [63:0] b;
	logic [63:0] r;
	logic [4:0] rd;
	logic [15:0] imm;
	int pc_idx;
	int steps;
	store_list_t stores;
	for (int i = 0; i < 32; i++)
		regs[i] = '0;
	for (int i = 0; i < 256; i++)
		mem[i] = dmem[i];
	pc_idx = 0;
	steps = 0;
	while (pc_idx < prog_len && steps < 1000)
	begin
		w = prog[pc_idx];
		rd = w[25:21];
		imm = w[15:0];
		a = regs[w[20:16]];
		b = regs[w[15:11]];
		pc_idx++;
		steps++;
		case (w[31:26])
			cpu_pkg::OP_LW:
				if (rd != 0)
					regs[rd] = mem[imm[7:0]];
			cpu_pkg::OP_SW:
			begin
				stores.push_back(store_t'({32'(imm), regs[rd]}));
				mem[imm[7:0]] = regs[rd];
			end
			cpu_pkg::OP_BEQ:
				if (regs[rd] == '0)
					pc_idx = int'(imm >> 2);
			cpu_pkg::OP_BNE:
				if (regs[rd] != '0)
					pc_idx = int'(imm >> 2);
			cpu_pkg::OP_RTYPE:
			begin
				case (w[5:0])
					cpu_pkg::FN_AND: r = a & b;
					cpu_pkg::FN_OR: r = a | b;
					cpu_pkg::FN_XOR: r = a ^ b;
					cpu_pkg::FN_NOT: r = ~a;
					cpu_pkg::FN_MOV: r = a;
					cpu_pkg::FN_ADD: r = lane_op(a, b, w[7:6], 1'b0);
					cpu_pkg::FN_SUB: r = lane_op(a, b, w[7:6], 1'b1);
					default: r = '0;
				endcase
				if (rd != 0)
					regs[rd] = (regs[rd] & ~part_mask(w[10:8])) | (r & part_mask(w[10:8]));
			end
			default: ;
		endcase
	end
	return stores;
endfunction

`endif

//--- testbench/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

	localparam int PROG_SLOTS = 96;
	localparam int N_TESTS = 6;
	localparam int WATCHDOG_NS = (PROG_SLOTS + 20) * 4 * N_TESTS;

	logic clk;
	logic reset;
	logic [31:0] instruction;
	logic [63:0] data_in;
	logic [31:0] pc;
	logic [63:0] data_out;
	logic [31:0] mem_addr;
	logic mem_en;
	logic mem_wr_en;

	logic [31:0] prog [PROG_SLOTS];
	int prog_len;
	logic [63:0] dmem [256];
	string cur_test;
	int errors;
	int stores_seen;
	int seed;
	logic rd_pend;
	logic [7:0] rd_addr;

	`include "cpu_ref.svh"

	store_list_t expected;
	store_t exp_store;

	cpu_top DUT (
		.clk(clk),
		.reset(reset),
		.instruction(instruction),
		.data_in(data_in),
		.pc(pc),
		.data_out(data_out),
		.mem_addr(mem_addr),
		.mem_en(mem_en),
		.mem_wr_en(mem_wr_en)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check(input string what, input logic [63:0] exp_val,
			input logic [63:0] act_val);
		if (exp_val !== act_val)
		begin
			errors++;
			$display("** Error [%s] %s: expected %h, actual %h", cur_test, what, exp_val, act_val);
		end
	endtask

	// instruction memory returns nop beyond the program
	function automatic logic [31:0] fetch_word(logic [31:0] addr);
		if ((addr >> 2) < PROG_SLOTS)
			return prog[addr >> 2];
		return nop_word();
	endfunction

	task automatic build_test(int t);
		case (t)
			0:
			begin
				start_program("loads_stores");
				emit_spaced(itype_word(cpu_pkg::OP_LW, 1, 'h10));
				emit_spaced(itype_word(cpu_pkg::OP_SW, 1, 'h80));
				emit_spaced(itype_word(cpu_pkg::OP_LW, 2, 'h18));
				emit_spaced(itype_word(cpu_pkg::OP_SW, 2, 'h88));
			end
			1:
			begin
				start_program("logic_ops");
				emit_spaced(itype_word(cpu_pkg::OP_LW, 1, 'h20));
				emit_spaced(itype_word(cpu_pkg::OP_LW, 2, 'h28));
				// and, or, xor, not, mov into r3..r7
				for (int f = 0; f < 5; f++)
					emit_spaced(rtype_word(cpu_pkg::func_t'(f), 3 + f, 1, 2, 0, 0));
				for (int f = 0; f < 5; f++)
					emit_spaced(itype_word(cpu_pkg::OP_SW, 3 + f, 'h90 + 8 * f));
			end
			2:
			begin
				start_program("lane_add_sub");
				emit_spaced(itype_word(cpu_pkg::OP_LW, 1, 'h30));
				emit_spaced(itype_word(cpu_pkg::OP_LW, 2, 'h38));
				for (int lane = 0; lane < 4; lane++)
				begin
					emit_spaced(rtype_word(cpu_pkg::FN_ADD, 3, 1, 2, 0, lane));
					emit_spaced(rtype_word(cpu_pkg::FN_SUB, 4, 1, 2, 0, lane));
					emit_spaced(itype_word(cpu_pkg::OP_SW, 3, 'ha0 + 16 * lane));
					emit_spaced(itype_word(cpu_pkg::OP_SW, 4, 'ha8 + 16 * lane));
				end
			end
			3:
			begin
				start_program("part_select");
				emit_spaced(itype_word(cpu_pkg::OP_LW, 2, 'h40));
				// codes 5 to 7 select nothing
				for (int p = 0; p < 8; p++)
				begin
					emit_spaced(itype_word(cpu_pkg::OP_LW, 3, 'h48));
					emit_spaced(rtype_word(cpu_pkg::FN_MOV, 3, 2, 0, p, 0));
					emit_spaced(itype_word(cpu_pkg::OP_SW, 3, 'hc0 + 8 * p));
				end
			end
			4:
			begin
				start_program("branches");
				emit_spaced(rtype_word(cpu_pkg::FN_NOT, 1, 0, 0, 0, 0));
				branch_over(cpu_pkg::OP_BEQ, 0, 'h50, 'h58);
				branch_over(cpu_pkg::OP_BNE, 1, 'h60, 'h68);
				branch_over(cpu_pkg::OP_BEQ, 1, 'h70, 'h78);
				branch_over(cpu_pkg::OP_BNE, 0, 'h80, 'h88);
			end
			default:
			begin
				start_program("reg_zero");
				emit_spaced(itype_word(cpu_pkg::OP_LW, 1, 'h08));
				emit_spaced(rtype_word(cpu_pkg::FN_MOV, 0, 1, 0, 0, 0));
				emit_spaced(itype_word(cpu_pkg::OP_LW, 0, 'h10));
				emit_spaced(itype_word(cpu_pkg::OP_SW, 0, 'h18));
				emit_spaced(itype_word(cpu_pkg::OP_SW, 1, 'h20));
			end
		endcase
	endtask

	// synchronous data memory answers one cycle after the enable pulse
	always @(negedge clk)
	begin
		rd_pend = mem_en && !mem_wr_en;
		rd_addr = mem_addr[7:0];
		if (mem_en && mem_wr_en)
			dmem[mem_addr[7:0]] = data_out;
	end

	always @(posedge clk)
	begin
		#1;
		instruction = fetch_word(pc);
		if (rd_pend)
			data_in = dmem[rd_addr];
	end

	always @(negedge clk)
	begin
		if (reset && (mem_en || mem_wr_en))
		begin
			errors++;
			$display("memory pulse seen while reset is high in test %s", cur_test);
		end
		if (mem_wr_en)
			check("mem_en with write", 64'd1, 64'(mem_en));
		if (mem_wr_en && !reset)
		begin
			if (expected.size() == 0)
			begin
				errors++;
				$display("unexpected store to address %h in test %s", mem_addr, cur_test);
			end
			else
			begin
				exp_store = expected.pop_front();
				check("store address", 64'(exp_store.addr), 64'(mem_addr));
				check("store data", exp_store.data, data_out);
				stores_seen++;
			end
		end
	end

	initial
	begin
		#(WATCHDOG_NS);
		$display("run timed out after %0d ns with tests still running", WATCHDOG_NS);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		reset = 1'b1;
		instruction = nop_word();
		data_in = '0;
		rd_pend = 1'b0;
		rd_addr = '0;
		errors = 0;
		stores_seen = 0;
		prog_len = 0;
		seed = 76;
		for (int i = 0; i < 256; i++)
			dmem[i] = {$random(seed), $random(seed)};
		for (int t = 0; t < N_TESTS; t++)
		begin
			@(posedge clk);
			#1;
			reset = 1'b1;
			build_test(t);
			expected = run_reference();
			repeat (5) @(posedge clk);
			#1;
			reset = 1'b0;
			// run until the last slot is fetched and the pipeline drains
			while (pc < 32'(4 * prog_len))
				@(negedge clk);
			repeat (6) @(negedge clk);
			if (expected.size() != 0)
			begin
				errors++;
				$display("test %s ended with %0d stores missing", cur_test, expected.size());
			end
		end
		// back to back loads, reset rises while their pulses are in flight
		@(posedge clk);
		#1;
		reset = 1'b1;
		start_program("reset_flush");
		for (int i = 0; i < 8; i++)
			push_word(itype_word(cpu_pkg::OP_LW, 1 + i, 8 * i));
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		while (mem_en !== 1'b1)
			@(negedge clk);
		@(posedge clk);
		#1;
		reset = 1'b1;
		repeat (2) @(negedge clk);
		$display("errors: %0d, stores checked: %0d over %0d tests", errors, stores_seen, N_TESTS);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
